//--- src/excp_pkg.sv
// Shared definitions for the exception subsystem
// Cause-vector bit indices, exception type codes, CP0 register numbers,
// CP0 field positions, exception vector bases and offsets, width typedefs

package excp_pkg;

    localparam int EXC_W = 20;

    typedef logic [EXC_W-1:0] exc_vec_t;
    typedef logic [4:0]       exc_type_t;
    typedef logic [31:0]      word_t;
    typedef logic [4:0]       cp0_addr_t;

    // Cause vector bit indices, lower index means higher priority
    localparam int EXC_INTR     = 1;
    localparam int EXC_I_ADEL   = 2;   // Fetch address error
    localparam int EXC_I_TLBR   = 3;   // Fetch TLB refill
    localparam int EXC_I_TLBI   = 4;   // Fetch TLB invalid
    localparam int EXC_CPU      = 6;
    localparam int EXC_RI       = 7;
    localparam int EXC_OV       = 8;
    localparam int EXC_TRAP     = 9;
    localparam int EXC_SYSC     = 10;
    localparam int EXC_BP       = 11;
    localparam int EXC_D_ADEL   = 12;
    localparam int EXC_D_ADES   = 13;
    localparam int EXC_D_TLBR   = 14;
    localparam int EXC_D_TLBI   = 15;
    localparam int EXC_D_TLBM   = 16;
    localparam int EXC_ERET     = 18;

    // Slots 0, 5, 17 and 19 carry no cause in this core
    localparam exc_vec_t EXC_USED_MASK = 20'h5_FFDE;

    // ExcCode values as written to Cause, plus two internal codes
    localparam exc_type_t EXT_INT  = 5'd0;
    localparam exc_type_t EXT_TLBM = 5'd1;
    localparam exc_type_t EXT_TLBL = 5'd2;
    localparam exc_type_t EXT_TLBS = 5'd3;
    localparam exc_type_t EXT_ADEL = 5'd4;
    localparam exc_type_t EXT_ADES = 5'd5;
    localparam exc_type_t EXT_SYS  = 5'd8;
    localparam exc_type_t EXT_BP   = 5'd9;
    localparam exc_type_t EXT_RI   = 5'd10;
    localparam exc_type_t EXT_CPU  = 5'd11;
    localparam exc_type_t EXT_OV   = 5'd12;
    localparam exc_type_t EXT_TR   = 5'd13;
    localparam exc_type_t EXT_ERET = 5'd30;
    localparam exc_type_t EXT_NONE = 5'd31;

    // CP0 register numbers
    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

    // Status fields
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_ERL   = 2;
    localparam int STATUS_IM_LO = 8;
    localparam int STATUS_IM_HI = 15;
    localparam int STATUS_BEV   = 22;

    localparam word_t STATUS_RESET   = 32'h0040_0004;   // BEV and ERL set
    localparam word_t STATUS_WR_MASK = 32'h0040_FF07;   // IE, EXL, ERL, IM, BEV

    // Cause fields
    localparam int CAUSE_EXC_LO = 2;
    localparam int CAUSE_EXC_HI = 6;
    localparam int CAUSE_IP_LO  = 8;
    localparam int CAUSE_IP_HI  = 15;
    localparam int CAUSE_BD     = 31;

    // Exception vectors
    localparam word_t VEC_BASE_BOOT   = 32'hBFC0_0200;
    localparam word_t VEC_BASE_NORM   = 32'h8000_0000;
    localparam word_t VEC_OFF_REFILL  = 32'h0000_0000;
    localparam word_t VEC_OFF_GENERAL = 32'h0000_0180;

endpackage

//--- src/excp_commit_if.sv
// Exception decision bundle
// Carries the prioritized exception from the priority block to CP0
// and to the vector address block

interface excp_commit_if import excp_pkg::*; ();

    logic      flag;      // Exception or ERET present this cycle
    exc_type_t etype;     // Selected exception type
    word_t     baddr;     // Faulting address for BadVAddr
    logic      save_bad;  // Load BadVAddr on commit
    logic      refill;    // TLB refill, selects the refill vector offset

    // Driver side, the priority block
    modport prio (
        output flag,
        output etype,
        output baddr,
        output save_bad,
        output refill
    );

    // Consumers, CP0 and vector block
    modport sink (
        input flag,
        input etype,
        input baddr,
        input save_bad,
        input refill
    );

endinterface

//--- src/excp_prio.sv
// Exception prioritization
// Masks the pending hardware interrupt, merges in the data TLB faults
// and selects the highest-priority cause with its faulting address

module excp_prio import excp_pkg::*; (
    input  exc_vec_t      excp_in,
    input  logic          d_tlbr,
    input  logic          d_tlbi,
    input  logic          d_tlbm,
    input  logic          d_refs,    // Data access is a store
    input  word_t         status,
    input  word_t         cause,
    input  word_t         pc,
    input  word_t         m_vaddr,
    excp_commit_if.prio   commit
);

    logic     intr_req;
    exc_vec_t excp;
    logic [4:0] pick;   // Index of the winning cause bit

    // Pending and enabled interrupt, blocked at exception or error level
    assign intr_req = |(cause[CAUSE_IP_HI:CAUSE_IP_LO] & status[STATUS_IM_HI:STATUS_IM_LO])
                      &&  status[STATUS_IE]
                      && !status[STATUS_EXL]
                      && !status[STATUS_ERL];

    always_comb begin
        excp             = excp_in & EXC_USED_MASK;
        excp[EXC_INTR]   = intr_req;
        excp[EXC_D_TLBR] = d_tlbr;
        excp[EXC_D_TLBI] = d_tlbi;
        excp[EXC_D_TLBM] = d_tlbm;
    end

    assign commit.flag = |excp;

    // Scan downwards so the lowest set index is the one left in pick
    always_comb begin
        pick = '0;
        for (int i = EXC_W - 1; i >= 0; i--) begin
            if (excp[i]) pick = 5'(i);
        end
    end

    always_comb begin
        commit.etype    = EXT_NONE;
        commit.baddr    = '0;
        commit.save_bad = 1'b0;
        commit.refill   = 1'b0;
        if (commit.flag) begin
            case (pick)
                EXC_INTR:   commit.etype = EXT_INT;
                EXC_I_ADEL: commit.etype = EXT_ADEL;
                EXC_I_TLBR: commit.etype = EXT_TLBL;
                EXC_I_TLBI: commit.etype = EXT_TLBL;
                EXC_CPU:    commit.etype = EXT_CPU;
                EXC_RI:     commit.etype = EXT_RI;
                EXC_OV:     commit.etype = EXT_OV;
                EXC_TRAP:   commit.etype = EXT_TR;
                EXC_SYSC:   commit.etype = EXT_SYS;
                EXC_BP:     commit.etype = EXT_BP;
                EXC_D_ADEL: commit.etype = EXT_ADEL;
                EXC_D_ADES: commit.etype = EXT_ADES;
                EXC_D_TLBR: commit.etype = d_refs ? EXT_TLBS : EXT_TLBL;
                EXC_D_TLBI: commit.etype = d_refs ? EXT_TLBS : EXT_TLBL;
                EXC_D_TLBM: commit.etype = EXT_TLBM;   // Always Mod
                EXC_ERET:   commit.etype = EXT_ERET;
                default:    commit.etype = EXT_NONE;
            endcase

            case (pick)
                EXC_I_ADEL, EXC_I_TLBR, EXC_I_TLBI: begin
                    commit.baddr    = pc;   // Fetch fault
                    commit.save_bad = 1'b1;
                end
                EXC_D_ADEL, EXC_D_ADES, EXC_D_TLBR, EXC_D_TLBI, EXC_D_TLBM: begin
                    commit.baddr    = m_vaddr;
                    commit.save_bad = 1'b1;
                end
                default: begin
                    commit.baddr    = '0;
                    commit.save_bad = 1'b0;
                end
            endcase

            commit.refill = (pick == 5'(EXC_I_TLBR)) || (pick == 5'(EXC_D_TLBR));
        end
    end

endmodule

//--- src/cp0_regs.sv
// CP0 Status, Cause, EPC and BadVAddr registers
// Exception commit and ERET update, hardware interrupt sampling,
// move-to and move-from access for software

module cp0_regs import excp_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          stall,
    excp_commit_if.sink   commit,
    input  word_t         pc,
    input  logic          in_delay_slot,
    input  logic [5:0]    hw_int,
    input  logic          wr_en,
    input  cp0_addr_t     wr_addr,
    input  word_t         wr_data,
    input  cp0_addr_t     rd_addr,
    output word_t         rd_data,
    output word_t         status,
    output word_t         cause,
    output word_t         epc
);

    word_t status_q;
    word_t badvaddr_q;
    word_t epc_q;
    logic       cause_bd_q;
    logic [5:0] cause_ip_hw_q;   // Sampled hw_int, IP[7:2]
    logic [1:0] cause_ip_sw_q;   // Software interrupts, IP[1:0]
    exc_type_t  cause_exc_q;

    logic do_commit;
    logic is_eret;
    logic sw_wr;

    assign do_commit = commit.flag && !stall;
    assign is_eret   = (commit.etype == EXT_ERET);
    assign sw_wr     = wr_en && !stall && !do_commit;   // Exception wins over mtc0

    // Hardware IP bits follow hw_int one cycle late
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cause_ip_hw_q <= '0;
        end else if (!stall) begin
            cause_ip_hw_q <= hw_int;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_q      <= STATUS_RESET;
            epc_q         <= '0;
            badvaddr_q    <= '0;
            cause_bd_q    <= 1'b0;
            cause_ip_sw_q <= '0;
            cause_exc_q   <= '0;
        end else if (do_commit) begin
            if (is_eret) begin
                // Error level returns first
                if (status_q[STATUS_ERL]) begin
                    status_q[STATUS_ERL] <= 1'b0;
                end else begin
                    status_q[STATUS_EXL] <= 1'b0;
                end
            end else begin
                // Nested exceptions keep the first EPC and BD
                if (!status_q[STATUS_EXL]) begin
                    epc_q      <= in_delay_slot ? pc - 32'd4 : pc;
                    cause_bd_q <= in_delay_slot;
                end
                cause_exc_q          <= commit.etype;
                status_q[STATUS_EXL] <= 1'b1;
                if (commit.save_bad) begin
                    badvaddr_q <= commit.baddr;
                end
            end
        end else if (sw_wr) begin
            case (wr_addr)
                CP0_STATUS: begin
                    status_q <= (status_q & ~STATUS_WR_MASK) | (wr_data & STATUS_WR_MASK);
                end
                CP0_CAUSE:  cause_ip_sw_q <= wr_data[CAUSE_IP_LO+1:CAUSE_IP_LO];
                CP0_EPC:    epc_q <= wr_data;
                default:    ;   // BadVAddr and others are read only
            endcase
        end
    end

    // Cause as seen by software and the priority block
    always_comb begin
        cause                              = '0;
        cause[CAUSE_BD]                    = cause_bd_q;
        cause[CAUSE_IP_HI:CAUSE_IP_LO]     = {cause_ip_hw_q, cause_ip_sw_q};
        cause[CAUSE_EXC_HI:CAUSE_EXC_LO]   = cause_exc_q;
    end

    assign status = status_q;
    assign epc    = epc_q;

    // mfc0 read port
    always_comb begin
        case (rd_addr)
            CP0_BADVADDR: rd_data = badvaddr_q;
            CP0_STATUS:   rd_data = status_q;
            CP0_CAUSE:    rd_data = cause;
            CP0_EPC:      rd_data = epc_q;
            default:      rd_data = '0;
        endcase
    end

endmodule

//--- src/excp_vector.sv
// Exception vector address
// Redirect target from the exception type, Status.BEV and Status.EXL,
// or EPC when the instruction is ERET

module excp_vector import excp_pkg::*; (
    excp_commit_if.sink   commit,
    input  word_t         status,
    input  word_t         epc,
    output word_t         redirect_pc
);

    word_t base;
    word_t offset;
    logic  use_refill;

    // Boot-time vectors live in uncached ROM space
    assign base = status[STATUS_BEV] ? VEC_BASE_BOOT : VEC_BASE_NORM;

    // Refill gets its own entry only outside exception level
    assign use_refill = commit.refill && !status[STATUS_EXL];

    assign offset = use_refill ? VEC_OFF_REFILL : VEC_OFF_GENERAL;

    always_comb begin
        if (commit.etype == EXT_ERET) begin
            redirect_pc = epc;   // Return from handler
        end else begin
            redirect_pc = base + offset;
        end
    end

endmodule

//--- src/excp_unit.sv
// Exception handling subsystem top level
// Priority block, CP0 registers and vector block joined by one
// commit interface, with plain ports toward the pipeline

module excp_unit import excp_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         stall,          // Memory stage held, no commit

    // Exception sources from the memory stage
    input  exc_vec_t     excp_in,
    input  logic         d_tlbr,
    input  logic         d_tlbi,
    input  logic         d_tlbm,
    input  logic         d_refs,
    input  word_t        pc,
    input  word_t        m_vaddr,
    input  logic         in_delay_slot,
    input  logic [5:0]   hw_int,

    // Software access to CP0
    input  logic         cp0_wr_en,
    input  cp0_addr_t    cp0_wr_addr,
    input  word_t        cp0_wr_data,
    input  cp0_addr_t    cp0_rd_addr,
    output word_t        cp0_rd_data,

    // Decision toward the pipeline
    output logic         exc_flag,
    output exc_type_t    exc_type,
    output word_t        redirect_pc,
    output logic         flush
);

    word_t status;
    word_t cause;
    word_t epc;

    excp_commit_if commit_if ();

    excp_prio prio_i (
        .excp_in  (excp_in),
        .d_tlbr   (d_tlbr),
        .d_tlbi   (d_tlbi),
        .d_tlbm   (d_tlbm),
        .d_refs   (d_refs),
        .status   (status),
        .cause    (cause),
        .pc       (pc),
        .m_vaddr  (m_vaddr),
        .commit   (commit_if.prio)
    );

    cp0_regs cp0_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall         (stall),
        .commit        (commit_if.sink),
        .pc            (pc),
        .in_delay_slot (in_delay_slot),
        .hw_int        (hw_int),
        .wr_en         (cp0_wr_en),
        .wr_addr       (cp0_wr_addr),
        .wr_data       (cp0_wr_data),
        .rd_addr       (cp0_rd_addr),
        .rd_data       (cp0_rd_data),
        .status        (status),
        .cause         (cause),
        .epc           (epc)
    );

    excp_vector vector_i (
        .commit      (commit_if.sink),
        .status      (status),
        .epc         (epc),
        .redirect_pc (redirect_pc)
    );

    assign exc_flag = commit_if.flag;
    assign flush    = commit_if.flag;   // Any exception or ERET empties the pipe
    assign exc_type = commit_if.etype;

endmodule

//--- bench/excp_unit_assert.sv
// Bound checker for the exception unit
// Reference model of cause priority and vector address, shadow EPC and
// BadVAddr, concurrent assertions on priority, masking, commit, stall, ERET

module excp_unit_assert import excp_pkg::*; (
    input logic       clk,
    input logic       arst_n,
    input logic       stall,
    input exc_vec_t   excp_in,
    input logic       d_tlbr,
    input logic       d_tlbi,
    input logic       d_tlbm,
    input logic       d_refs,
    input word_t      pc,
    input word_t      m_vaddr,
    input logic       in_delay_slot,
    input logic [5:0] hw_int,
    input logic       cp0_wr_en,
    input cp0_addr_t  cp0_wr_addr,
    input word_t      cp0_wr_data,
    input cp0_addr_t  cp0_rd_addr,
    input word_t      cp0_rd_data,
    input logic       exc_flag,
    input exc_type_t  exc_type,
    input word_t      redirect_pc,
    input logic       flush,
    input word_t      status,
    input word_t      cause,
    input word_t      epc
);

    timeunit 1ns;
    timeprecision 100ps;

    bit        failed = 1'b0;   // Watched by the testbench
    logic      intr_ok;
    exc_vec_t  merged;
    int        top;             // Winning cause index, -1 when none
    exc_type_t want;
    logic      fault;
    logic      commit;
    word_t     vec_exp;
    word_t     epc_exp;
    word_t     bad_exp;

    assign intr_ok = |(cause[15:8] & status[15:8]) && status[STATUS_IE]
                     && !status[STATUS_EXL] && !status[STATUS_ERL];

    always_comb begin
        // Unused slots dropped, interrupt and data TLB pins merged in
        merged = {1'b0, excp_in[18], 1'b0, d_tlbm, d_tlbi, d_tlbr, excp_in[13:6],
                  1'b0, excp_in[4:2], intr_ok, 1'b0};
        top = -1;
        for (int i = 0; i < EXC_W; i++) begin
            if (merged[i] && top < 0) top = i;
        end
        case (top)
            EXC_INTR:               want = EXT_INT;
            EXC_I_ADEL, EXC_D_ADEL: want = EXT_ADEL;
            EXC_I_TLBR, EXC_I_TLBI: want = EXT_TLBL;   // Fetch is a load
            EXC_CPU:                want = EXT_CPU;
            EXC_RI:                 want = EXT_RI;
            EXC_OV:                 want = EXT_OV;
            EXC_TRAP:               want = EXT_TR;
            EXC_SYSC:               want = EXT_SYS;
            EXC_BP:                 want = EXT_BP;
            EXC_D_ADES:             want = EXT_ADES;
            EXC_D_TLBR, EXC_D_TLBI: want = d_refs ? EXT_TLBS : EXT_TLBL;
            EXC_D_TLBM:             want = EXT_TLBM;
            EXC_ERET:               want = EXT_ERET;
            default:                want = EXT_NONE;
        endcase
        fault = (top >= EXC_I_ADEL && top <= EXC_I_TLBI)
             || (top >= EXC_D_ADEL && top <= EXC_D_TLBM);
        vec_exp = (status[STATUS_BEV] ? VEC_BASE_BOOT : VEC_BASE_NORM)
                + (((top == EXC_I_TLBR || top == EXC_D_TLBR) && !status[STATUS_EXL])
                   ? VEC_OFF_REFILL : VEC_OFF_GENERAL);
        if (want == EXT_ERET) begin
            vec_exp = epc_exp;
        end
    end

    assign commit = (top >= 0) && !stall;

    // Shadow EPC and BadVAddr
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            epc_exp <= '0;
            bad_exp <= '0;
        end else if (commit) begin
            if (want != EXT_ERET && !status[STATUS_EXL]) begin
                epc_exp <= in_delay_slot ? pc - 32'd4 : pc;
            end
            if (fault) begin
                bad_exp <= (top <= EXC_I_TLBI) ? pc : m_vaddr;
            end
        end else if (!stall && cp0_wr_en && cp0_wr_addr == CP0_EPC) begin
            epc_exp <= cp0_wr_data;
        end
    end

    task automatic note_fail(input string msg);
        failed = 1'b1;
        $error("%s", msg);
    endtask

    a_prio: assert property (@(posedge clk) disable iff (!arst_n)
        exc_type == want && exc_flag == (top >= 0) && flush == (top >= 0))
        else note_fail($sformatf("error exc_type 0x%h expected 0x%h exc_flag 0x%h flush 0x%h",
                                 $sampled(exc_type), $sampled(want), $sampled(exc_flag),
                                 $sampled(flush)));

    a_int_mask: assert property (@(posedge clk) disable iff (!arst_n)
        (!status[STATUS_IE] || status[STATUS_EXL]) |-> exc_type != EXT_INT)
        else note_fail("interrupt taken while IE was clear or EXL was set");

    a_ip_sample: assert property (@(posedge clk) disable iff (!arst_n)
        !stall |=> cause[15:10] == $past(hw_int))
        else note_fail("hw_int did not reach Cause.IP one cycle later");

    a_vector: assert property (@(posedge clk) disable iff (!arst_n)
        exc_flag |-> redirect_pc == vec_exp)
        else note_fail($sformatf("error redirect_pc 0x%h expected 0x%h",
                                 $sampled(redirect_pc), $sampled(vec_exp)));

    a_epc_read: assert property (@(posedge clk) disable iff (!arst_n)
        cp0_rd_addr == CP0_EPC |-> cp0_rd_data == epc_exp)
        else note_fail($sformatf("error cp0_rd_data 0x%h expected EPC 0x%h",
                                 $sampled(cp0_rd_data), $sampled(epc_exp)));

    a_bad_read: assert property (@(posedge clk) disable iff (!arst_n)
        cp0_rd_addr == CP0_BADVADDR |-> cp0_rd_data == bad_exp)
        else note_fail($sformatf("error cp0_rd_data 0x%h expected BadVAddr 0x%h",
                                 $sampled(cp0_rd_data), $sampled(bad_exp)));

    a_commit: assert property (@(posedge clk) disable iff (!arst_n)
        commit && want != EXT_ERET |=> status[STATUS_EXL] && cause[6:2] == $past(want))
        else note_fail("exception commit did not set EXL and ExcCode");

    a_eret: assert property (@(posedge clk) disable iff (!arst_n)
        commit && want == EXT_ERET |=>
            ($past(status[STATUS_ERL]) ? !status[STATUS_ERL] : !status[STATUS_EXL]))
        else note_fail("ERET did not clear ERL or EXL");

    a_stall: assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> $stable(status) && $stable(cause) && $stable(epc))
        else note_fail("CP0 state changed while the stage was stalled");

endmodule

// Checker instance inside every excp_unit
bind excp_unit excp_unit_assert assert_i (.*);

//--- bench/tb_excp_unit.sv
// Testbench for the exception unit
// Clock, reset, watchdog, directed and random stimulus; the bound
// checker holds the assertions

module tb_excp_unit import excp_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 100;
    localparam int DIRECTED_STEPS = 60;    // Upper bound on directed cycles
    localparam int RANDOM_CYCLES  = 400;
    localparam int TIMEOUT        = (DIRECTED_STEPS + RANDOM_CYCLES + 20) * CLK_PERIOD;

    logic       clk;
    logic       arst_n;
    logic       stall;
    exc_vec_t   excp_in;
    logic       d_tlbr;
    logic       d_tlbi;
    logic       d_tlbm;
    logic       d_refs;
    word_t      pc;
    word_t      m_vaddr;
    logic       in_delay_slot;
    logic [5:0] hw_int;
    logic       cp0_wr_en;
    cp0_addr_t  cp0_wr_addr;
    word_t      cp0_wr_data;
    cp0_addr_t  cp0_rd_addr;
    word_t      cp0_rd_data;
    logic       exc_flag;
    exc_type_t  exc_type;
    word_t      redirect_pc;
    logic       flush;
    integer     seed;

    excp_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic idle_inputs();
        stall         = 1'b0;
        excp_in       = '0;
        d_tlbr        = 1'b0;
        d_tlbi        = 1'b0;
        d_tlbm        = 1'b0;
        d_refs        = 1'b0;
        pc            = 32'h0040_0000;
        m_vaddr       = '0;
        in_delay_slot = 1'b0;
        hw_int        = '0;
        cp0_wr_en     = 1'b0;
        cp0_wr_addr   = '0;
        cp0_wr_data   = '0;
        cp0_rd_addr   = CP0_EPC;
    endtask

    task automatic cp0_write(input cp0_addr_t addr, input word_t data);
        cp0_wr_en   = 1'b1;
        cp0_wr_addr = addr;
        cp0_wr_data = data;
        next_cycle();
        cp0_wr_en   = 1'b0;
    endtask

    // One cycle with a single cause, bits 14 to 16 go through the TLB pins
    task automatic take_cause(input int idx, input logic store);
        excp_in       = '0;
        excp_in[idx]  = (idx < EXC_D_TLBR) || (idx > EXC_D_TLBM);
        d_tlbr        = (idx == EXC_D_TLBR);
        d_tlbi        = (idx == EXC_D_TLBI);
        d_tlbm        = (idx == EXC_D_TLBM);
        d_refs        = store;
        pc            = 32'h0040_0000 + 32'(idx) * 32'd8;
        m_vaddr       = 32'h1000_0000 ^ (32'(idx) << 4);
        in_delay_slot = (idx % 2) == 1;
        cp0_rd_addr   = CP0_BADVADDR;
        next_cycle();
        excp_in       = '0;
        d_tlbr        = 1'b0;
        d_tlbi        = 1'b0;
        d_tlbm        = 1'b0;
    endtask

    task automatic eret();
        excp_in           = '0;
        excp_in[EXC_ERET] = 1'b1;
        cp0_rd_addr       = CP0_EPC;
        next_cycle();
        excp_in           = '0;
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Some tests failed");
        $fatal(1, "timeout, the stimulus did not finish in time");
    end

    // Stop at the first assertion failure
    initial begin
        wait (dut_i.assert_i.failed);
        $display("Some tests failed");
        $fatal(1, "an assertion in the bound checker failed");
    end

    initial begin
        seed   = 97861;
        arst_n = 1'b0;
        idle_inputs();
        repeat (3) @(posedge clk);
        #5;
        arst_n = 1'b1;

        cp0_write(CP0_STATUS, 32'h0040_0000);   // Leave error level, BEV kept
        for (int i = EXC_I_ADEL; i <= EXC_D_TLBM; i++) begin
            take_cause(i, (i % 3) == 0);
            eret();
        end

        stall = 1'b1;                           // Decisions seen but not committed
        take_cause(EXC_OV, 1'b0);
        take_cause(EXC_D_ADES, 1'b1);
        stall = 1'b0;

        cp0_write(CP0_STATUS, 32'h0000_0000);   // Normal vectors
        take_cause(EXC_I_TLBR, 1'b0);
        take_cause(EXC_D_TLBR, 1'b1);           // Nested refill, general offset
        eret();

        cp0_write(CP0_STATUS, 32'h0000_FF01);   // IE and all IM bits
        hw_int = 6'b000100;
        repeat (3) next_cycle();
        hw_int = '0;
        eret();
        cp0_write(CP0_STATUS, 32'h0000_FF00);   // IE clear, no Int allowed
        hw_int = 6'b111111;
        repeat (3) next_cycle();
        hw_int = '0;

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            excp_in       = exc_vec_t'($random(seed) & $random(seed) & $random(seed));
            d_tlbr        = ({$random(seed)} % 8) == 0;
            d_tlbi        = ({$random(seed)} % 8) == 0;
            d_tlbm        = ({$random(seed)} % 8) == 0;
            d_refs        = $random(seed);
            pc            = $random(seed);
            m_vaddr       = $random(seed);
            in_delay_slot = $random(seed);
            stall         = ({$random(seed)} % 4) == 0;
            hw_int        = (({$random(seed)} % 8) == 0) ? 6'($random(seed)) : 6'd0;
            cp0_wr_en     = ({$random(seed)} % 16) == 0;
            cp0_wr_addr   = CP0_STATUS + 5'({$random(seed)} % 3);
            cp0_wr_data   = $random(seed);
            cp0_rd_addr   = ({$random(seed)} % 2) ? CP0_EPC : CP0_BADVADDR;
            next_cycle();
        end

        idle_inputs();
        repeat (2) next_cycle();
        if (dut_i.assert_i.failed) begin
            $display("Some tests failed");
            $fatal(1, "an assertion in the bound checker failed");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

//--- list.f
src/excp_pkg.sv
src/excp_commit_if.sv
src/excp_prio.sv
src/cp0_regs.sv
src/excp_vector.sv
src/excp_unit.sv
bench/excp_unit_assert.sv
bench/tb_excp_unit.sv

//--- Bender.yml
package:
  name: excp_unit

sources:
  - files:
      - src/excp_pkg.sv
      - src/excp_commit_if.sv
      - src/excp_prio.sv
      - src/cp0_regs.sv
      - src/excp_vector.sv
      - src/excp_unit.sv
  - target: any(test, simulation)
    files:
      - bench/excp_unit_assert.sv
      - bench/tb_excp_unit.sv
